//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - id_control.sv
      - imm_target_gen.sv
      - reg_file.sv
      - hazard_window.sv
      - decode_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv

//--- decode_pkg.sv
package decode_pkg;

    // Raw instruction word
    typedef logic [31:0] inst_t;

    // Packet from fetch
    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;
    } fetch_t;

    // One register file write
    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wb_t;

    // Bundle handed to execute
    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;
        logic [31:0] imm;
        // Integer operands
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        // FP operands
        logic [31:0] fs1_val;
        logic [31:0] fs2_val;
        logic [31:0] fs3_val;
        // Branch or JAL destination
        logic [31:0] target;
        logic        target_valid;
    } decoded_t;

endpackage

//--- decode_stage.sv
module decode_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  decode_pkg::fetch_t   in,
    output logic                 in_ready,
    output logic                 out_valid,
    input  logic                 out_ready,
    output decode_pkg::decoded_t out,
    input  decode_pkg::wb_t      int_wb,
    input  decode_pkg::wb_t      fp_wb
);
    import decode_pkg::*;

    inst_t       ex_inst;
    inst_t       mem_inst;
    logic [2:0]  imm_sel;
    logic        target_gen_sel;
    logic        target_gen_en;
    logic        stall;
    logic [31:0] imm;
    logic [31:0] target;
    logic        target_valid;
    logic        issue;
    logic        advance;
    logic [4:0]  int_raddr [2];
    logic [31:0] int_rdata [2];
    logic [4:0]  fp_raddr  [3];
    logic [31:0] fp_rdata  [3];

    // Handshake gating
    assign out_valid = in_valid && !stall;
    assign in_ready  = out_ready && !stall;
    assign issue     = in_valid && in_ready;
    assign advance   = out_ready;

    id_control u_id_control (
        .inst           (in.inst),
        .ex_inst        (ex_inst),
        .mem_inst       (mem_inst),
        .imm_sel        (imm_sel),
        .target_gen_sel (target_gen_sel),
        .target_gen_en  (target_gen_en),
        .stall          (stall)
    );

    imm_target_gen u_imm_target_gen (
        .inst           (in.inst),
        .pc             (in.pc),
        .imm_sel        (imm_sel),
        .target_gen_sel (target_gen_sel),
        .target_gen_en  (target_gen_en),
        .imm            (imm),
        .target         (target),
        .target_valid   (target_valid)
    );

    hazard_window u_hazard_window (
        .clk        (clk),
        .rst        (rst),
        .issue      (issue),
        .issue_inst (in.inst),
        .advance    (advance),
        .ex_inst    (ex_inst),
        .mem_inst   (mem_inst)
    );

    // rs1 and rs2 fields, plus rs3 for FMADD
    assign int_raddr[0] = in.inst[19:15];
    assign int_raddr[1] = in.inst[24:20];
    assign fp_raddr[0]  = in.inst[19:15];
    assign fp_raddr[1]  = in.inst[24:20];
    assign fp_raddr[2]  = in.inst[31:27];

    reg_file #(
        .NUM_READ (2),
        .ZERO_REG (1'b1)
    ) int_rf (
        .clk   (clk),
        .rst   (rst),
        .wb    (int_wb),
        .raddr (int_raddr),
        .rdata (int_rdata)
    );

    reg_file #(
        .NUM_READ (3),
        .ZERO_REG (1'b0)
    ) fp_rf (
        .clk   (clk),
        .rst   (rst),
        .wb    (fp_wb),
        .raddr (fp_raddr),
        .rdata (fp_rdata)
    );

    assign out = '{
        pc:           in.pc,
        inst:         in.inst,
        imm:          imm,
        rs1_val:      int_rdata[0],
        rs2_val:      int_rdata[1],
        fs1_val:      fp_rdata[0],
        fs2_val:      fp_rdata[1],
        fs3_val:      fp_rdata[2],
        target:       target,
        target_valid: target_valid
    };

endmodule

//--- hazard_window.sv
`include "rv_settings.svh"

module hazard_window (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue,
    input  decode_pkg::inst_t issue_inst,
    input  logic              advance,
    output decode_pkg::inst_t ex_inst,
    output decode_pkg::inst_t mem_inst
);

    // Two-deep record of the words ahead of decode
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_inst  <= `NOP_INST;
            mem_inst <= `NOP_INST;
        end else if (advance) begin
            // Bubble when decode had nothing to send
            if (issue) begin
                ex_inst <= issue_inst;
            end else begin
                ex_inst <= `NOP_INST;
            end
            mem_inst <= ex_inst;
        end
    end

endmodule

//--- id_control.sv
`include "rv_settings.svh"

module id_control (
    input  decode_pkg::inst_t inst,
    input  decode_pkg::inst_t ex_inst,
    input  decode_pkg::inst_t mem_inst,
    output logic [2:0]        imm_sel,
    output logic              target_gen_sel,
    output logic              target_gen_en,
    output logic              stall
);
    import decode_pkg::*;

    // Writes an integer destination
    function automatic logic writes_rd(inst_t i);
        logic [6:0] op;
        op = i[6:0];
        return op != `OPC_STORE && op != `OPC_BRANCH && op != `OPC_CSR &&
               op != `OPC_FP_LOAD && op != `OPC_FP_STORE && op != `OPC_FP_MADD &&
               (op != `OPC_FP || i[31:25] == `FNC7_FP_MV_X_W);
    endfunction

    // Writes an FP destination
    function automatic logic writes_fd(inst_t i);
        logic [6:0] op;
        op = i[6:0];
        return op == `OPC_FP_LOAD || op == `OPC_FP_MADD ||
               (op == `OPC_FP && i[31:25] != `FNC7_FP_MV_X_W);
    endfunction

    function automatic logic is_load(inst_t i);
        return i[6:2] == `OPC_LOAD_5 || i[6:2] == `OPC_FP_LOAD_5;
    endfunction

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [4:0] rs1, rs2, fs3;
    logic       has_rs1, has_rs2, has_fs1, has_fs2, has_fs3;
    logic       is_store;
    logic [4:0] ex_rd, mem_rd;
    logic       ex_has_rd, ex_has_fd, mem_has_rd, mem_has_fd;
    logic       ex_load;
    logic       ex_int_hit, ex_fp_hit, mem_int_hit, mem_fp_hit;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // fs1 and fs2 share the rs1 and rs2 fields
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign fs3 = inst[31:27];

    // Source usage of the word in decode
    assign has_rs1 = opcode != `OPC_AUIPC && opcode != `OPC_LUI && opcode != `OPC_JAL &&
                     (opcode != `OPC_CSR || funct3 == `FNC_CSRRW) &&
                     opcode != `OPC_FP_MADD &&
                     (opcode != `OPC_FP || funct7 == `FNC7_FP_MV_W_X ||
                      funct7 == `FNC7_FP_CVT_S_W) &&
                     rs1 != 5'd0;
    assign has_rs2 = (opcode == `OPC_ARI_RTYPE || opcode == `OPC_STORE ||
                      opcode == `OPC_BRANCH) && rs2 != 5'd0;
    assign has_fs1 = opcode == `OPC_FP_MADD ||
                     (opcode == `OPC_FP && (funct7 == `FNC7_FP_MV_X_W ||
                      funct7 == `FNC7_FP_FSGNJ_S || funct7 == `FNC7_FP_ADD));
    assign has_fs2 = opcode == `OPC_FP_STORE || opcode == `OPC_FP_MADD ||
                     (opcode == `OPC_FP && (funct7 == `FNC7_FP_FSGNJ_S ||
                      funct7 == `FNC7_FP_ADD));
    assign has_fs3 = opcode == `OPC_FP_MADD;
    assign is_store = opcode == `OPC_STORE || opcode == `OPC_FP_STORE;

    // Destinations of the words further down the pipe
    assign ex_rd      = ex_inst[11:7];
    assign mem_rd     = mem_inst[11:7];
    assign ex_has_rd  = writes_rd(ex_inst);
    assign ex_has_fd  = writes_fd(ex_inst);
    assign mem_has_rd = writes_rd(mem_inst);
    assign mem_has_fd = writes_fd(mem_inst);
    assign ex_load    = is_load(ex_inst);

    assign ex_int_hit  = (has_rs1 && rs1 == ex_rd) || (has_rs2 && rs2 == ex_rd);
    assign ex_fp_hit   = (has_fs1 && rs1 == ex_rd) || (has_fs2 && rs2 == ex_rd) ||
                         (has_fs3 && fs3 == ex_rd);
    assign mem_int_hit = (has_rs1 && rs1 == mem_rd) || (has_rs2 && rs2 == mem_rd);
    assign mem_fp_hit  = (has_fs1 && rs1 == mem_rd) || (has_fs2 && rs2 == mem_rd) ||
                         (has_fs3 && fs3 == mem_rd);

    // Loads in ex and all producers in mem hold decode since nothing bypasses writeback
    always_comb begin
        stall = 1'b0;
        // Load in ex feeding an ALU op
        if (!is_store && ex_load && ex_has_rd && ex_int_hit) begin
            stall = 1'b1;
        end
        // Load in ex feeding an FPU op
        if (ex_load && ex_has_fd && ex_fp_hit) begin
            stall = 1'b1;
        end
        // Store base from a load in ex
        if (is_store && ex_load && ex_has_rd && has_rs1 && rs1 == ex_rd) begin
            stall = 1'b1;
        end
        // Any producer sitting in mem
        if (mem_has_rd && mem_int_hit) begin
            stall = 1'b1;
        end
        if (mem_has_fd && mem_fp_hit) begin
            stall = 1'b1;
        end
    end

    // Immediate format and target source
    always_comb begin
        imm_sel        = `IMM_DONT_CARE;
        target_gen_sel = `TGT_GEN_DONT_CARE;
        target_gen_en  = 1'b0;
        case (inst[6:2])
            `OPC_ARI_ITYPE_5, `OPC_LOAD_5, `OPC_JALR_5, `OPC_FP_LOAD_5: begin
                imm_sel = `IMM_I;
            end
            `OPC_STORE_5, `OPC_FP_STORE_5: begin
                imm_sel = `IMM_S;
            end
            `OPC_BRANCH_5: begin
                case (funct3)
                    `FNC_BEQ, `FNC_BNE, `FNC_BLT, `FNC_BGE, `FNC_BLTU, `FNC_BGEU: begin
                        imm_sel        = `IMM_B;
                        target_gen_sel = `TGT_GEN_BR;
                        target_gen_en  = 1'b1;
                    end
                    default: ;
                endcase
            end
            `OPC_JAL_5: begin
                imm_sel        = `IMM_J;
                target_gen_sel = `TGT_GEN_JAL;
                target_gen_en  = 1'b1;
            end
            `OPC_LUI_5, `OPC_AUIPC_5: begin
                imm_sel = `IMM_U;
            end
            // R-type, CSR and FP arithmetic carry no immediate
            default: ;
        endcase
    end

endmodule

//--- imm_target_gen.sv
`include "rv_settings.svh"

module imm_target_gen (
    input  decode_pkg::inst_t inst,
    input  logic [31:0]       pc,
    input  logic [2:0]        imm_sel,
    input  logic              target_gen_sel,
    input  logic              target_gen_en,
    output logic [31:0]       imm,
    output logic [31:0]       target,
    output logic              target_valid
);

    logic [31:0] imm_b;
    logic [31:0] imm_j;

    // Branch and JAL offsets feed the target adder directly
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (imm_sel)
            `IMM_I:  imm = {{20{inst[31]}}, inst[31:20]};
            `IMM_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            `IMM_B:  imm = imm_b;
            `IMM_J:  imm = imm_j;
            `IMM_U:  imm = {inst[31:12], 12'b0};
            default: imm = 32'b0;
        endcase
    end

    always_comb begin
        target = 32'b0;
        if (target_gen_en) begin
            if (target_gen_sel == `TGT_GEN_JAL) begin
                target = pc + imm_j;
            end else begin
                target = pc + imm_b;
            end
        end
    end

    assign target_valid = target_gen_en;

endmodule

//--- reg_file.sv
module reg_file #(
    parameter int NUM_READ = 2,
    // Register 0 reads as zero when set
    parameter bit ZERO_REG = 1'b1
) (
    input  logic              clk,
    input  logic              rst,
    input  decode_pkg::wb_t   wb,
    input  logic [4:0]        raddr [NUM_READ],
    output logic [31:0]       rdata [NUM_READ]
);

    logic [31:0] regs [32];
    logic        wr_ok;

    // Drop writes to the hardwired zero register
    assign wr_ok = wb.en && !(ZERO_REG && wb.addr == 5'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wr_ok) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Reads see the array as it stands, no write bypass
    for (genvar g = 0; g < NUM_READ; g++) begin : g_read
        assign rdata[g] = regs[raddr[g]];
    end

endmodule

//--- rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Full 7-bit opcodes
`define OPC_LUI          7'b0110111
`define OPC_AUIPC        7'b0010111
`define OPC_JAL          7'b1101111
`define OPC_JALR         7'b1100111
`define OPC_BRANCH       7'b1100011
`define OPC_STORE        7'b0100011
`define OPC_LOAD         7'b0000011
`define OPC_ARI_RTYPE    7'b0110011
`define OPC_ARI_ITYPE    7'b0010011
`define OPC_CSR          7'b1110011
`define OPC_FP_LOAD      7'b0000111
`define OPC_FP_STORE     7'b0100111
`define OPC_FP           7'b1010011
`define OPC_FP_MADD      7'b1000011

// Opcodes without the two low bits
`define OPC_LUI_5        5'b01101
`define OPC_AUIPC_5      5'b00101
`define OPC_JAL_5        5'b11011
`define OPC_JALR_5       5'b11001
`define OPC_BRANCH_5     5'b11000
`define OPC_STORE_5      5'b01000
`define OPC_LOAD_5       5'b00000
`define OPC_ARI_RTYPE_5  5'b01100
`define OPC_ARI_ITYPE_5  5'b00100
`define OPC_CSR_5        5'b11100
`define OPC_FP_LOAD_5    5'b00001
`define OPC_FP_STORE_5   5'b01001
`define OPC_FP_5         5'b10100
`define OPC_FP_MADD_5    5'b10000

// Branch funct3
`define FNC_BEQ          3'b000
`define FNC_BNE          3'b001
`define FNC_BLT          3'b100
`define FNC_BGE          3'b101
`define FNC_BLTU         3'b110
`define FNC_BGEU         3'b111

// CSR funct3
`define FNC_CSRRW        3'b001

// FP funct7 and funct4
`define FNC7_FP_ADD      7'b0000000
`define FNC7_FP_FSGNJ_S  7'b0010000
`define FNC7_FP_MV_X_W   7'b1110000
`define FNC7_FP_MV_W_X   7'b1111000
`define FNC7_FP_CVT_S_W  7'b1101000
`define FNC4_FP_ADD      4'b0000
`define FNC4_FP_FSGNJ_S  4'b0010
`define FNC4_FP_MV_X_W   4'b1110
`define FNC4_FP_MV_W_X   4'b1111
`define FNC4_FP_CVT_S_W  4'b1101

// Immediate formats
`define IMM_I            3'd0
`define IMM_S            3'd1
`define IMM_B            3'd2
`define IMM_J            3'd3
`define IMM_U            3'd4
`define IMM_DONT_CARE    3'd7

// Target sources
`define TGT_GEN_BR        1'b0
`define TGT_GEN_JAL       1'b1
`define TGT_GEN_DONT_CARE 1'b0

// ADDI x0, x0, 0
`define NOP_INST         32'h0000_0013

`endif

//--- sources.f
+incdir+.
decode_pkg.sv
id_control.sv
imm_target_gen.sv
reg_file.sv
hazard_window.sv
decode_stage.sv
tb_decode_stage.sv

//--- tb_decode_stage.sv
`include "rv_settings.svh"

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_ROWS   = 32;

    // One table row with stimulus first and expected results after
    typedef struct packed {
        logic [31:0] pc;
        inst_t       inst;
        logic [3:0]  hold;
        logic [1:0]  wb_kind;
        logic [4:0]  wb_addr;
        logic [31:0] imm;
        logic        tv;
        logic [31:0] target;
        logic [1:0]  stall;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    fetch_t      in;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready;
    decoded_t    out;
    wb_t         int_wb;
    wb_t         fp_wb;

    row_t        rows [MAX_ROWS];
    string       names [MAX_ROWS];
    int          n_rows = 0;
    logic        table_done = 1'b0;
    int          checks = 0;
    int          errors = 0;
    string       cur_name = "reset";
    // Shadow register files and ex/mem window
    logic [31:0] sh_int [32];
    logic [31:0] sh_fp [32];
    inst_t       sh_ex;
    inst_t       sh_mem;

    decode_stage DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Instruction encoders for each format
    function automatic inst_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic inst_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic inst_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic inst_t enc_u(logic [19:0] upper, logic [4:0] rd, logic [6:0] op);
        return {upper, rd, op};
    endfunction

    task automatic add_case(string name, inst_t inst, logic [3:0] hold, logic [31:0] imm,
                            logic tv, logic [31:0] target, logic [1:0] stall,
                            logic [1:0] wb_kind = 2'd0, logic [4:0] wb_addr = 5'd0);
        rows[n_rows] = '{pc: 32'h100 + 32'(4 * n_rows), inst: inst, hold: hold,
                         wb_kind: wb_kind, wb_addr: wb_addr, imm: imm, tv: tv,
                         target: target, stall: stall};
        names[n_rows] = name;
        n_rows++;
    endtask

    task automatic check_val(string what, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    // Compare the DUT window with the shadow and then step the shadow
    task automatic sample(output logic acc);
        @(negedge clk);
        check_val("ex_inst", sh_ex, DUT.u_hazard_window.ex_inst);
        check_val("mem_inst", sh_mem, DUT.u_hazard_window.mem_inst);
        acc = in_valid && in_ready;
        if (out_ready) begin
            sh_mem = sh_ex;
            sh_ex  = acc ? in.inst : `NOP_INST;
        end
    endtask

    task automatic apply_case(int k);
        row_t        c;
        logic [31:0] d;
        logic        acc;
        decoded_t    held;
        int          low_cnt;
        int          waited;
        c        = rows[k];
        cur_name = names[k];
        low_cnt  = 0;
        waited   = 0;
        @(posedge clk);
        // A writeback gets an idle cycle of its own
        if (c.wb_kind != 2'd0) begin
            d = $urandom();
            in_valid <= 1'b0;
            if (c.wb_kind == 2'd1) begin
                int_wb <= '{en: 1'b1, addr: c.wb_addr, data: d};
            end else begin
                fp_wb <= '{en: 1'b1, addr: c.wb_addr, data: d};
            end
            sample(acc);
            @(posedge clk);
            if (c.wb_kind == 2'd2) begin
                sh_fp[c.wb_addr] = d;
            end else if (c.wb_addr != 5'd0) begin
                sh_int[c.wb_addr] = d;
            end
        end
        int_wb    <= '0;
        fp_wb     <= '0;
        in_valid  <= 1'b1;
        in        <= '{pc: c.pc, inst: c.inst};
        out_ready <= (c.hold == 4'd0);
        acc = 1'b0;
        while (!acc) begin
            sample(acc);
            if (!out_ready) begin
                // Held bundle must not move
                check_val("in_ready", 1'b0, in_ready);
                if (low_cnt == 0) begin
                    held = out;
                end else begin
                    checks++;
                    assert (out === held) else begin
                        errors++;
                        $display("ERR %s out expected %h actual %h", cur_name, held, out);
                    end
                end
                low_cnt++;
                @(posedge clk);
                out_ready <= (low_cnt >= c.hold);
            end else if (!acc) begin
                // A stalled bundle is not offered to execute
                check_val("out_valid", 1'b0, out_valid);
                waited++;
                @(posedge clk);
            end
        end
        check_val("stall_cycles", c.stall, waited);
        check_val("out_valid", 1'b1, out_valid);
        check_val("pc", c.pc, out.pc);
        check_val("inst", c.inst, out.inst);
        check_val("imm", c.imm, out.imm);
        check_val("target_valid", c.tv, out.target_valid);
        if (c.tv) begin
            check_val("target", c.target, out.target);
        end
        check_val("rs1_val", sh_int[c.inst[19:15]], out.rs1_val);
        check_val("rs2_val", sh_int[c.inst[24:20]], out.rs2_val);
        check_val("fs1_val", sh_fp[c.inst[19:15]], out.fs1_val);
        check_val("fs2_val", sh_fp[c.inst[24:20]], out.fs2_val);
        check_val("fs3_val", sh_fp[c.inst[31:27]], out.fs3_val);
    endtask

    // Ten clock periods per table row
    initial begin
        wait (table_done);
        #(n_rows * 10 * CLK_PERIOD);
        $display("Timeout: the DUT stopped accepting instructions");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic        acc;
        logic [31:0] d_int;
        logic [31:0] d_fp;
        void'($urandom(15695));
        rst       = 1'b1;
        in_valid  = 1'b0;
        in        = '0;
        out_ready = 1'b1;
        int_wb    = '0;
        fp_wb     = '0;
        sh_ex     = `NOP_INST;
        sh_mem    = `NOP_INST;

        // name, inst, hold, imm, target_valid, target, stall, writeback kind and address
        add_case("addi_imm_i", enc_i(12'hffb, 1, 0, 5, `OPC_ARI_ITYPE), 0, 32'hfffffffb, 0, 0, 0);
        add_case("sw_imm_s", enc_s(12'h00c, 2, 3, 3'b010, `OPC_STORE), 0, 32'h0000000c, 0, 0, 0);
        add_case("beq_target", enc_b(13'h1ff8, 7, 6, `FNC_BEQ), 0, 32'hfffffff8, 1, 32'h100, 0);
        add_case("jal_target", enc_j(21'h1ff804, 1), 0, 32'hfffff804, 1, 32'hfffff910, 0);
        add_case("lui_imm_u", enc_u(20'h12345, 8, `OPC_LUI), 0, 32'h12345000, 0, 0, 0);
        add_case("add_after_lui", enc_r(0, 10, 8, 0, 9, `OPC_ARI_RTYPE), 0, 0, 0, 0, 0);
        add_case("addi_two_apart", enc_i(12'h7ff, 8, 0, 11, `OPC_ARI_ITYPE), 0, 32'h7ff, 0, 0, 1);
        add_case("lw_producer", enc_i(12'h000, 4, 3'b010, 12, `OPC_LOAD), 0, 0, 0, 0, 0);
        add_case("add_load_use", enc_r(0, 2, 12, 0, 13, `OPC_ARI_RTYPE), 0, 0, 0, 0, 2);
        add_case("ori_backpressure", enc_i(12'hfff, 3, 3'b110, 14, `OPC_ARI_ITYPE),
                 3, 32'hffffffff, 0, 0, 0);
        add_case("flw_producer", enc_i(12'h008, 5, 3'b010, 1, `OPC_FP_LOAD), 0, 32'h8, 0, 0, 0);
        add_case("fadd_load_use", enc_r(`FNC7_FP_ADD, 3, 1, 0, 4, `OPC_FP), 0, 0, 0, 0, 2);
        add_case("fsgnj", enc_r(`FNC7_FP_FSGNJ_S, 7, 6, 0, 5, `OPC_FP), 0, 0, 0, 0, 0);
        // rs3 is f4 as written by the FADD two slots earlier
        add_case("fmadd_two_apart", enc_r({5'd4, 2'b00}, 10, 9, 0, 8, `OPC_FP_MADD),
                 0, 0, 0, 0, 1);
        add_case("fmv_x_w", enc_r(`FNC7_FP_MV_X_W, 0, 8, 0, 15, `OPC_FP), 0, 0, 0, 0, 0);
        add_case("fmv_w_x", enc_r(`FNC7_FP_MV_W_X, 0, 15, 0, 11, `OPC_FP), 0, 0, 0, 0, 0);
        add_case("fcvt_two_apart", enc_r(`FNC7_FP_CVT_S_W, 0, 15, 0, 12, `OPC_FP), 0, 0, 0, 0, 1);
        add_case("fsw_x0_base", enc_s(12'h004, 12, 0, 3'b010, `OPC_FP_STORE), 0, 32'h4, 0, 0, 0);
        add_case("int_writeback", enc_r(0, 0, 20, 0, 21, `OPC_ARI_RTYPE), 0, 0, 0, 0, 0, 1, 20);
        add_case("fp_writeback", enc_r(`FNC7_FP_FSGNJ_S, 13, 13, 0, 14, `OPC_FP),
                 0, 0, 0, 0, 0, 2, 13);
        add_case("lw_base", enc_i(12'h000, 1, 3'b010, 16, `OPC_LOAD), 0, 0, 0, 0, 0);
        add_case("sw_base_hazard", enc_s(12'h000, 17, 16, 3'b010, `OPC_STORE), 2, 0, 0, 0, 2);
        add_case("blt_target", enc_b(13'h0804, 19, 18, `FNC_BLT), 0, 32'h804, 1, 32'h95c, 0);
        table_done = 1'b1;

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Nothing offered yet
        sample(acc);
        check_val("out_valid", 1'b0, out_valid);
        check_val("in_ready", 1'b1, in_ready);

        // Fill both register files including the ignored x0 write
        cur_name = "reg_fill";
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            d_int = $urandom();
            d_fp  = $urandom();
            int_wb <= '{en: 1'b1, addr: 5'(r), data: d_int};
            fp_wb  <= '{en: 1'b1, addr: 5'(r), data: d_fp};
            sh_int[r] = (r == 0) ? 32'b0 : d_int;
            sh_fp[r]  = d_fp;
            sample(acc);
        end

        for (int k = 0; k < n_rows; k++) begin
            apply_case(k);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
